//--- design/gbpt_params.svh
`ifndef GBPT_PARAMS_SVH
`define GBPT_PARAMS_SVH

// ------------------------------------------------
// Predictor sizing
// ------------------------------------------------

// Global history bits carried with each request
`define GH_LENGTH 12

// Address space ID width
`define ASID_WIDTH 9

// Table index width, 256 entries
`define GBPT_INDEX_WIDTH 8

// Counter value after reset, weakly not-taken
`define GBPT_CTR_INIT 2'b01

`endif

//--- design/core_types_pkg.sv
`default_nettype none

`include "gbpt_params.svh"

package core_types_pkg;

    // ------------------------------------------------
    // Vector types
    // ------------------------------------------------

    // Full fetch PC
    typedef logic [31:0] pc_t;

    // Global branch history
    typedef logic [`GH_LENGTH-1:0] gh_t;

    // Address space ID
    typedef logic [`ASID_WIDTH-1:0] asid_t;

    // Index into the counter table
    typedef logic [`GBPT_INDEX_WIDTH-1:0] gbpt_idx_t;

    // 2-bit saturating counter, upper bit is the taken prediction
    typedef logic [1:0] gbpt_ctr_t;

    // ------------------------------------------------
    // Index hash, shared by lookup and update
    // ------------------------------------------------

    function automatic gbpt_idx_t gbpt_hash(input pc_t pc, input gh_t gh, input asid_t asid);
        gbpt_idx_t pc_bits;
        gbpt_idx_t gh_bits;
        gbpt_idx_t asid_bits;
        // PC from bit 1 up, bit 0 carries no information
        pc_bits = gbpt_idx_t'(pc >> 1);
        // Low history bits
        gh_bits = gbpt_idx_t'(gh);
        // Low ASID bits, zero-extended if narrower
        asid_bits = gbpt_idx_t'(asid);
        return pc_bits ^ gh_bits ^ asid_bits;
    endfunction

endpackage

`default_nettype wire

//--- design/gbpt_array_upd_if.sv
`default_nettype none

interface gbpt_array_upd_if;

    // Update-side read port
    core_types_pkg::gbpt_idx_t upd_rd_index;
    core_types_pkg::gbpt_ctr_t upd_rd_counter;

    // Write port, driven from update1
    logic                      wr_valid;
    core_types_pkg::gbpt_idx_t wr_index;
    core_types_pkg::gbpt_ctr_t wr_counter;

    // Counter storage side
    modport array (
        input  upd_rd_index,
        output upd_rd_counter,
        input  wr_valid,
        input  wr_index,
        input  wr_counter
    );

    // Read-modify-write side
    modport updater (
        output upd_rd_index,
        input  upd_rd_counter,
        output wr_valid,
        output wr_index,
        output wr_counter
    );

endinterface

`default_nettype wire

//--- design/gbpt_array.sv
`default_nettype none

`include "gbpt_params.svh"

module gbpt_array (
    input  wire logic                      CLK,
    input  wire logic                      nRST,

    // Lookup read port
    input  wire core_types_pkg::gbpt_idx_t lookup_index,
    output      core_types_pkg::gbpt_ctr_t lookup_counter,

    // Update read and write ports
    gbpt_array_upd_if.array                upd
);

    localparam int unsigned NUM_ENTRIES = 1 << `GBPT_INDEX_WIDTH;

    // ------------------------------------------------
    // Counter storage
    // ------------------------------------------------

    core_types_pkg::gbpt_ctr_t counters [NUM_ENTRIES];

    // Write on the edge, so same-cycle reads see the old value
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            // Every entry back to weakly not-taken
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                counters[i] <= `GBPT_CTR_INIT;
            end
        end else if (upd.wr_valid) begin
            counters[upd.wr_index] <= upd.wr_counter;
        end
    end

    // ------------------------------------------------
    // Combinational read ports
    // ------------------------------------------------

    // Prediction side
    assign lookup_counter = counters[lookup_index];

    // Training side
    assign upd.upd_rd_counter = counters[upd.upd_rd_index];

endmodule

`default_nettype wire

//--- design/gbpt_lookup.sv
`default_nettype none

module gbpt_lookup (
    input  wire logic                      CLK,
    input  wire logic                      nRST,

    // RESP stage request
    input  wire logic                      valid_RESP,
    input  wire core_types_pkg::pc_t       full_PC_RESP,
    input  wire core_types_pkg::gh_t       GH_RESP,
    input  wire core_types_pkg::asid_t     ASID_RESP,

    // Table read
    output      core_types_pkg::gbpt_idx_t lookup_index,
    input  wire core_types_pkg::gbpt_ctr_t lookup_counter,

    // RESTART stage prediction
    output      logic                      pred_taken_RESTART
);

    // Index from PC, history and ASID
    assign lookup_index = core_types_pkg::gbpt_hash(full_PC_RESP, GH_RESP, ASID_RESP);

    // Counter upper bit into RESTART, hold between requests
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            pred_taken_RESTART <= 1'b0;
        end else if (valid_RESP) begin
            pred_taken_RESTART <= lookup_counter[1];
        end
    end

endmodule

`default_nettype wire

//--- design/gbpt_updater.sv
`default_nettype none

module gbpt_updater (
    input  wire logic                  CLK,
    input  wire logic                  nRST,

    // Update0 stage keys and resolved direction
    input  wire logic                  update0_valid,
    input  wire core_types_pkg::pc_t   update0_start_full_PC,
    input  wire core_types_pkg::gh_t   update0_GH,
    input  wire core_types_pkg::asid_t update0_ASID,
    input  wire logic                  update0_taken,

    // Counter array access
    gbpt_array_upd_if.updater          upd,

    // Update1 result
    output      logic                  update1_correct
);

    // ------------------------------------------------
    // Update0 stage
    // ------------------------------------------------

    core_types_pkg::gbpt_idx_t update0_index;
    core_types_pkg::gbpt_ctr_t update0_counter;
    logic                      fwd_hit;

    // Update1 state
    logic                      update1_valid;
    core_types_pkg::gbpt_idx_t update1_index;
    core_types_pkg::gbpt_ctr_t update1_old_counter;
    logic                      update1_taken;
    core_types_pkg::gbpt_ctr_t update1_new_counter;

    assign update0_index = core_types_pkg::gbpt_hash(update0_start_full_PC, update0_GH,
                                                     update0_ASID);
    assign upd.upd_rd_index = update0_index;

    // Array not yet written by update1, take its value directly
    assign fwd_hit = update1_valid && (update1_index == update0_index);
    assign update0_counter = fwd_hit ? update1_new_counter : upd.upd_rd_counter;

    // ------------------------------------------------
    // Update1 registers
    // ------------------------------------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            update1_valid <= 1'b0;
        end else begin
            update1_valid <= update0_valid;
        end
    end

    // Payload, qualified by update1_valid
    always_ff @(posedge CLK) begin
        update1_index       <= update0_index;
        update1_old_counter <= update0_counter;
        update1_taken       <= update0_taken;
    end

    // ------------------------------------------------
    // Update1 stage
    // ------------------------------------------------

    // Saturating step toward the resolved direction
    always_comb begin
        if (update1_taken) begin
            update1_new_counter = (update1_old_counter == 2'b11) ? 2'b11
                                                                 : update1_old_counter + 2'd1;
        end else begin
            update1_new_counter = (update1_old_counter == 2'b00) ? 2'b00
                                                                 : update1_old_counter - 2'd1;
        end
    end

    // Write-back lands on the next edge
    assign upd.wr_valid   = update1_valid;
    assign upd.wr_index   = update1_index;
    assign upd.wr_counter = update1_new_counter;

    // Old counter would have predicted this direction
    assign update1_correct = update1_valid && (update1_old_counter[1] == update1_taken);

endmodule

`default_nettype wire

//--- design/gbpt.sv
`default_nettype none

module gbpt (
    input  wire logic                  CLK,
    input  wire logic                  nRST,

    // RESP stage
    input  wire logic                  valid_RESP,
    input  wire core_types_pkg::pc_t   full_PC_RESP,
    input  wire core_types_pkg::gh_t   GH_RESP,
    input  wire core_types_pkg::asid_t ASID_RESP,

    // RESTART stage
    output      logic                  pred_taken_RESTART,

    // Update0 stage
    input  wire logic                  update0_valid,
    input  wire core_types_pkg::pc_t   update0_start_full_PC,
    input  wire core_types_pkg::gh_t   update0_GH,
    input  wire core_types_pkg::asid_t update0_ASID,
    input  wire logic                  update0_taken,

    // Update1 stage
    output      logic                  update1_correct
);

    // Lookup read port
    core_types_pkg::gbpt_idx_t lookup_index;
    core_types_pkg::gbpt_ctr_t lookup_counter;

    // Update read and write ports
    gbpt_array_upd_if upd_if ();

    // ------------------------------------------------
    // Prediction path
    // ------------------------------------------------

    gbpt_lookup lookup (
        .CLK                (CLK),
        .nRST               (nRST),
        .valid_RESP         (valid_RESP),
        .full_PC_RESP       (full_PC_RESP),
        .GH_RESP            (GH_RESP),
        .ASID_RESP          (ASID_RESP),
        .lookup_index       (lookup_index),
        .lookup_counter     (lookup_counter),
        .pred_taken_RESTART (pred_taken_RESTART)
    );

    // Counter table
    gbpt_array array (
        .CLK            (CLK),
        .nRST           (nRST),
        .lookup_index   (lookup_index),
        .lookup_counter (lookup_counter),
        .upd            (upd_if.array)
    );

    // ------------------------------------------------
    // Training path
    // ------------------------------------------------

    gbpt_updater updater (
        .CLK                   (CLK),
        .nRST                  (nRST),
        .update0_valid         (update0_valid),
        .update0_start_full_PC (update0_start_full_PC),
        .update0_GH            (update0_GH),
        .update0_ASID          (update0_ASID),
        .update0_taken         (update0_taken),
        .upd                   (upd_if.updater),
        .update1_correct       (update1_correct)
    );

endmodule

`default_nettype wire

//--- design/gbpt_wrapper.sv
`default_nettype none

module gbpt_wrapper (
    input  wire logic                  CLK,
    input  wire logic                  nRST,

    // RESP stage request
    input  wire logic                  next_valid_RESP,
    input  wire core_types_pkg::pc_t   next_full_PC_RESP,
    input  wire core_types_pkg::gh_t   next_GH_RESP,
    input  wire core_types_pkg::asid_t next_ASID_RESP,

    // RESTART stage prediction
    output      logic                  last_pred_taken_RESTART,

    // Update0 request
    input  wire logic                  next_update0_valid,
    input  wire core_types_pkg::pc_t   next_update0_start_full_PC,
    input  wire core_types_pkg::gh_t   next_update0_GH,
    input  wire core_types_pkg::asid_t next_update0_ASID,
    input  wire logic                  next_update0_taken,

    // Update1 result
    output      logic                  last_update1_correct
);

    // ------------------------------------------------
    // Registered boundary signals
    // ------------------------------------------------

    logic                  valid_RESP;
    core_types_pkg::pc_t   full_PC_RESP;
    core_types_pkg::gh_t   GH_RESP;
    core_types_pkg::asid_t ASID_RESP;
    logic                  pred_taken_RESTART;

    logic                  update0_valid;
    core_types_pkg::pc_t   update0_start_full_PC;
    core_types_pkg::gh_t   update0_GH;
    core_types_pkg::asid_t update0_ASID;
    logic                  update0_taken;
    logic                  update1_correct;

    gbpt predictor (
        .CLK                   (CLK),
        .nRST                  (nRST),
        .valid_RESP            (valid_RESP),
        .full_PC_RESP          (full_PC_RESP),
        .GH_RESP               (GH_RESP),
        .ASID_RESP             (ASID_RESP),
        .pred_taken_RESTART    (pred_taken_RESTART),
        .update0_valid         (update0_valid),
        .update0_start_full_PC (update0_start_full_PC),
        .update0_GH            (update0_GH),
        .update0_ASID          (update0_ASID),
        .update0_taken         (update0_taken),
        .update1_correct       (update1_correct)
    );

    // ------------------------------------------------
    // Boundary registers
    // ------------------------------------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            // Request side
            valid_RESP   <= 1'b0;
            full_PC_RESP <= '0;
            GH_RESP      <= '0;
            ASID_RESP    <= '0;
            // Update side
            update0_valid         <= 1'b0;
            update0_start_full_PC <= '0;
            update0_GH            <= '0;
            update0_ASID          <= '0;
            update0_taken         <= 1'b0;
            // Outputs
            last_pred_taken_RESTART <= 1'b0;
            last_update1_correct    <= 1'b0;
        end else begin
            valid_RESP   <= next_valid_RESP;
            full_PC_RESP <= next_full_PC_RESP;
            GH_RESP      <= next_GH_RESP;
            ASID_RESP    <= next_ASID_RESP;
            update0_valid         <= next_update0_valid;
            update0_start_full_PC <= next_update0_start_full_PC;
            update0_GH            <= next_update0_GH;
            update0_ASID          <= next_update0_ASID;
            update0_taken         <= next_update0_taken;
            // One more stage on the way out
            last_pred_taken_RESTART <= pred_taken_RESTART;
            last_update1_correct    <= update1_correct;
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 5
) (
    output logic CLK,
    output logic nRST
);

    timeunit 1ns;
    timeprecision 100ps;

    // Free-running clock, starts low
    initial begin
        CLK = 1'b0;
        forever #(PERIOD_NS / 2) CLK = ~CLK;
    end

    // Reset held for a few cycles, released on a falling edge
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(negedge CLK);
        nRST = 1'b1;
    end

endmodule

`default_nettype wire

//--- testbench/tb_gbpt.sv
`default_nettype none

`include "gbpt_params.svh"

module tb_gbpt;

    timeunit 1ns;
    timeprecision 100ps;

    // Input to output latency in falling edges, from the wrapper timing
    localparam int PIPE_DEPTH    = 3;
    localparam int RESET_TIMEOUT = 20;
    localparam int WATCHDOG_NS   = 100000;

    logic                  CLK;
    logic                  nRST;
    logic                  next_valid_RESP;
    core_types_pkg::pc_t   next_full_PC_RESP;
    core_types_pkg::gh_t   next_GH_RESP;
    core_types_pkg::asid_t next_ASID_RESP;
    logic                  last_pred_taken_RESTART;
    logic                  next_update0_valid;
    core_types_pkg::pc_t   next_update0_start_full_PC;
    core_types_pkg::gh_t   next_update0_GH;
    core_types_pkg::asid_t next_update0_ASID;
    logic                  next_update0_taken;
    logic                  last_update1_correct;

    // Parsed testdata, one entry per operation line
    byte         op_q[$];
    logic [31:0] pc_q[$];
    logic [31:0] gh_q[$];
    logic [31:0] asid_q[$];
    logic        taken_q[$];
    logic        exp_q[$];
    int          line_q[$];

    // Checks waiting for their cycle
    logic  exp_pred_q[$];
    logic  exp_corr_q[$];
    string pred_name_q[$];
    string corr_name_q[$];

    int    num_checks;
    int    wait_count;
    int    idx;
    logic  pred_chk;
    logic  pred_exp;
    logic  corr_exp;
    logic  last_pred;
    string pred_name;
    string corr_name;

    tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(5)) clock_gen (
        .CLK  (CLK),
        .nRST (nRST)
    );

    gbpt_wrapper DUT (
        .CLK                        (CLK),
        .nRST                       (nRST),
        .next_valid_RESP            (next_valid_RESP),
        .next_full_PC_RESP          (next_full_PC_RESP),
        .next_GH_RESP               (next_GH_RESP),
        .next_ASID_RESP             (next_ASID_RESP),
        .last_pred_taken_RESTART    (last_pred_taken_RESTART),
        .next_update0_valid         (next_update0_valid),
        .next_update0_start_full_PC (next_update0_start_full_PC),
        .next_update0_GH            (next_update0_GH),
        .next_update0_ASID          (next_update0_ASID),
        .next_update0_taken         (next_update0_taken),
        .last_update1_correct       (last_update1_correct)
    );

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------

    // Table index for a key, only used to label checks
    function automatic logic [`GBPT_INDEX_WIDTH-1:0] table_index(input logic [31:0] pc,
                                                                input logic [31:0] gh,
                                                                input logic [31:0] asid);
        return pc[`GBPT_INDEX_WIDTH:1] ^ gh[`GBPT_INDEX_WIDTH-1:0] ^ asid[`GBPT_INDEX_WIDTH-1:0];
    endfunction

    function automatic string label_for(input int i, input string what);
        return $sformatf("line %0d %s idx %02h", line_q[i], what,
                         table_index(pc_q[i], gh_q[i], asid_q[i]));
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic compare_value(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("ERR %s expected %0b actual %0b", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end else begin
            num_checks++;
        end
    endtask

    task automatic load_testdata();
        int          fd;
        int          rc;
        int          line_no;
        string       text;
        byte         op;
        logic [31:0] pc;
        logic [31:0] gh;
        logic [31:0] asid;
        logic [31:0] taken;
        logic [31:0] exp_v;
        fd = $fopen("testbench/gbpt_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open testbench/gbpt_testdata.txt");
        end
        line_no = 0;
        while (!$feof(fd)) begin
            text = "";
            rc = $fgets(text, fd);
            line_no++;
            // Skip blank and comment lines
            if (rc > 0 && text.len() > 1 && text[0] != "#") begin
                rc = $sscanf(text, "%c %h %h %h %h %h", op, pc, gh, asid, taken, exp_v);
                if (rc != 6 || !(op == "P" || op == "U" || op == "C" || op == "I")) begin
                    abort_run($sformatf("Malformed testdata on line %0d", line_no));
                end
                op_q.push_back(op);
                pc_q.push_back(pc);
                gh_q.push_back(gh);
                asid_q.push_back(asid);
                taken_q.push_back(taken[0]);
                exp_q.push_back(exp_v[0]);
                line_q.push_back(line_no);
            end
        end
        $fclose(fd);
    endtask

    // All valids low, keys zero
    task automatic clear_inputs();
        next_valid_RESP            = 1'b0;
        next_full_PC_RESP          = '0;
        next_GH_RESP               = '0;
        next_ASID_RESP             = '0;
        next_update0_valid         = 1'b0;
        next_update0_start_full_PC = '0;
        next_update0_GH            = '0;
        next_update0_ASID          = '0;
        next_update0_taken         = 1'b0;
    endtask

    task automatic drive_predict(input int i);
        next_valid_RESP   = 1'b1;
        next_full_PC_RESP = pc_q[i];
        next_GH_RESP      = gh_q[i][`GH_LENGTH-1:0];
        next_ASID_RESP    = asid_q[i][`ASID_WIDTH-1:0];
    endtask

    task automatic drive_update(input int i);
        next_update0_valid         = 1'b1;
        next_update0_start_full_PC = pc_q[i];
        next_update0_GH            = gh_q[i][`GH_LENGTH-1:0];
        next_update0_ASID          = asid_q[i][`ASID_WIDTH-1:0];
        next_update0_taken         = taken_q[i];
    endtask

    task automatic push_expect(input logic pexp, input logic cexp,
                               input string pname, input string cname);
        exp_pred_q.push_back(pexp);
        exp_corr_q.push_back(cexp);
        pred_name_q.push_back(pname);
        corr_name_q.push_back(cname);
    endtask

    // Oldest cycle has reached the outputs, check and retire it
    task automatic check_due();
        if (exp_pred_q.size() == PIPE_DEPTH) begin
            compare_value(pred_name_q[0], exp_pred_q[0], last_pred_taken_RESTART);
            compare_value(corr_name_q[0], exp_corr_q[0], last_update1_correct);
            exp_pred_q.delete(0);
            exp_corr_q.delete(0);
            pred_name_q.delete(0);
            corr_name_q.delete(0);
        end
    endtask

    // --------------------------------------------------
    // Watchdog
    // --------------------------------------------------

    initial begin
        #(WATCHDOG_NS);
        $display("Simulation did not finish within the time limit");
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------

    initial begin
        clear_inputs();
        num_checks = 0;
        // Prediction register comes out of reset not-taken
        last_pred  = 1'b0;
        load_testdata();

        // Reset release, bounded
        wait_count = 0;
        while (nRST !== 1'b1 && wait_count < RESET_TIMEOUT) begin
            @(posedge CLK);
            wait_count++;
        end
        if (nRST !== 1'b1) begin
            abort_run("Reset was never released");
        end

        idx = 0;
        while (idx < op_q.size()) begin
            @(negedge CLK);
            check_due();
            clear_inputs();
            pred_chk  = 1'b0;
            // Without a request the prediction holds
            pred_exp  = last_pred;
            corr_exp  = 1'b0;
            pred_name = $sformatf("line %0d held pred", line_q[idx]);
            corr_name = $sformatf("line %0d idle correct", line_q[idx]);
            case (op_q[idx])
                "P", "C": begin
                    drive_predict(idx);
                    pred_chk  = 1'b1;
                    pred_exp  = exp_q[idx];
                    pred_name = label_for(idx, "pred");
                end
                "U": begin
                    drive_update(idx);
                    corr_exp  = exp_q[idx];
                    corr_name = label_for(idx, "correct");
                end
                default: begin
                    // Idle, correct flag must stay low
                end
            endcase
            idx++;
            // A C line shares the cycle of the line above it
            if (!pred_chk && idx < op_q.size() && op_q[idx] == "C") begin
                drive_predict(idx);
                pred_chk  = 1'b1;
                pred_exp  = exp_q[idx];
                pred_name = label_for(idx, "pred");
                idx++;
            end
            last_pred = pred_exp;
            push_expect(pred_exp, corr_exp, pred_name, corr_name);
        end

        // Flush the pipeline with idle cycles
        repeat (PIPE_DEPTH) begin
            @(negedge CLK);
            check_due();
            clear_inputs();
            push_expect(last_pred, 1'b0, "drain held pred", "drain correct");
        end

        if (num_checks == 0) begin
            $display("No checks ran, the testdata file held no operations");
            $display("TESTS FAILED");
            $fatal(1, "empty testdata");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- testbench/gbpt_testdata.txt
# op pc gh asid taken expected, all hex, one clock cycle per line
# op P predict, U update, C predict in the cycle of the line above, I idle
# expected is the prediction for P and C, the correct flag for U, 0 for I
# reset state, indices 20 b9 f9
P 00000040 000 000 0 0
P 00001234 abc 01f 0 0
P 8000fffe 5a5 0a3 0 0
I 00000000 000 000 0 0
I 00000000 000 000 0 0
# training to taken on index 20
U 00000040 000 000 1 0
I 00000000 000 000 0 0
I 00000000 000 000 0 0
U 00000040 000 000 1 1
I 00000000 000 000 0 0
I 00000000 000 000 0 0
P 00000040 000 000 0 1
# saturation at 3, then one not-taken
U 00000040 000 000 1 1
I 00000000 000 000 0 0
I 00000000 000 000 0 0
U 00000040 000 000 1 1
I 00000000 000 000 0 0
I 00000000 000 000 0 0
U 00000040 000 000 0 0
I 00000000 000 000 0 0
I 00000000 000 000 0 0
P 00000040 000 000 0 1
# back-to-back updates on index 00
U 00000200 000 000 1 0
U 00000200 000 000 1 1
I 00000000 000 000 0 0
I 00000000 000 000 0 0
U 00000200 000 000 0 0
I 00000000 000 000 0 0
I 00000000 000 000 0 0
P 00000200 000 000 0 1
# key separation, base 80, history 83, ASID 45
U 00000100 000 000 1 0
I 00000000 000 000 0 0
I 00000000 000 000 0 0
P 00000100 000 000 0 1
P 00000100 003 000 0 0
P 00000100 000 1c5 0 0
U 00000100 003 000 0 1
I 00000000 000 000 0 0
I 00000000 000 000 0 0
P 00000100 003 000 0 0
P 00000100 000 000 0 1
P 00000100 000 1c5 0 0
U 00000100 000 1c5 1 0
U 00000100 000 1c5 1 1
I 00000000 000 000 0 0
I 00000000 000 000 0 0
P 00000100 000 1c5 0 1
P 00000100 003 000 0 0
# prediction and update in one cycle
U 00000300 0f0 000 1 0
C 00000040 000 000 0 1
I 00000000 000 000 0 0
I 00000000 000 000 0 0
P 00000300 0f0 000 0 1
U 00000100 003 000 1 0
C 00000100 000 000 0 1
I 00000000 000 000 0 0
I 00000000 000 000 0 0
P 00000100 003 000 0 0

//--- vlog.f
+incdir+design
design/core_types_pkg.sv
design/gbpt_array_upd_if.sv
design/gbpt_array.sv
design/gbpt_lookup.sv
design/gbpt_updater.sv
design/gbpt.sv
design/gbpt_wrapper.sv
testbench/tb_clock_gen.sv
testbench/tb_gbpt.sv

//--- run_verilator.sh
#!/usr/bin/env bash
# Build the gbpt testbench with Verilator and run it from the project root
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_gbpt -Mdir obj_dir -f vlog.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/Vtb_gbpt
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation failed with status $sim_status"
fi

exit "$sim_status"
